/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

    parameter int BTB_NUM_DEF   = 8;
    parameter int BHT_IDX_W_DEF = 5;
    parameter int BHR_W_DEF     = 5;

    // gray-coded saturating counter, bit 1 set predicts taken
    typedef enum logic [1:0] {
        S_NT0 = 2'b00,
        S_NT1 = 2'b01,
        S_T1  = 2'b11,
        S_T0  = 2'b10
    } ctr_e;

    // branch outcome reported by the back end
    typedef struct packed {
        logic [fe_pkg::XLEN-1:0] pc;
        logic [fe_pkg::XLEN-1:0] target;
        logic                    taken;
        logic                    is_direct;
        logic                    is_cond;
    } resolve_t;

    function automatic ctr_e ctr_next(input ctr_e cur, input logic taken);
        ctr_e nxt;
        case (cur)
            S_NT0:   nxt = taken ? S_NT1 : S_NT0;
            S_NT1:   nxt = taken ? S_T1  : S_NT0;
            S_T1:    nxt = taken ? S_T0  : S_NT1;
            default: nxt = taken ? S_T0  : S_T1;
        endcase
        return nxt;
    endfunction

endpackage

`default_nettype wire

/* bp_tables.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_tables
    import fe_pkg::*;
    import bp_pkg::*;
#(
    parameter int BTB_NUM   = BTB_NUM_DEF,
    parameter int BHT_IDX_W = BHT_IDX_W_DEF,
    parameter int BHR_W     = BHR_W_DEF
) (
    input  wire             clk,
    input  wire             rstn,
    input  wire [XLEN-1:0]  lookup_pc_i,
    output logic            hit_o,
    output logic [XLEN-1:0] btb_target_o,
    output logic            cond_taken_o,
    output logic [XLEN-1:0] tc_target_o,
    input  wire             resolve_valid_i,
    input  wire resolve_t   resolve_i
);
    localparam int PTR_W   = $clog2(BTB_NUM);
    localparam int BHT_NUM = 2 ** BHT_IDX_W;
    localparam int PHT_NUM = 2 ** BHR_W;

    // btb for b, bl and jirl, tagged with pc[13:2]
    logic             btb_vld [BTB_NUM];
    logic [11:0]      btb_tag [BTB_NUM];
    logic [XLEN-1:0]  btb_tgt [BTB_NUM];
    logic [PTR_W-1:0] rr_ptr;

    // per-branch history, shared pattern table and target cache
    logic [BHR_W-1:0] bht [BHT_NUM];
    ctr_e             pht [PHT_NUM];
    logic [XLEN-1:0]  tc  [PHT_NUM];

    logic [BHT_IDX_W-1:0] lk_bht_idx;
    logic [BHR_W-1:0]     lk_pht_idx;
    ctr_e                 lk_ctr;
    logic [BHT_IDX_W-1:0] rs_bht_idx;
    logic [BHR_W-1:0]     rs_pht_idx;
    logic                 train_dir;
    logic                 train_cond;

    function automatic logic [BHT_IDX_W-1:0] bht_hash(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] sh16;
        logic [XLEN-1:0] sh8;
        sh16 = pc >> 16;
        sh8  = pc >> 8;
        return (pc[BHT_IDX_W-1:0] ^ sh16[BHT_IDX_W-1:0])
             + (pc[BHT_IDX_W-1:0] ^ sh8[BHT_IDX_W-1:0]);
    endfunction

    // lookup side
    always_comb begin
        hit_o        = 1'b0;
        btb_target_o = '0;
        // scan downwards so the lowest matching entry wins
        for (int i = BTB_NUM - 1; i >= 0; i--) begin
            if (btb_vld[i] && btb_tag[i] == lookup_pc_i[13:2]) begin
                hit_o        = 1'b1;
                btb_target_o = btb_tgt[i];
            end
        end
    end

    assign lk_bht_idx   = bht_hash(lookup_pc_i);
    assign lk_pht_idx   = bht[lk_bht_idx] ^ lookup_pc_i[BHR_W-1:0];
    assign lk_ctr       = pht[lk_pht_idx];
    assign cond_taken_o = (lk_ctr == S_T1) || (lk_ctr == S_T0);
    assign tc_target_o  = tc[lk_pht_idx];

    // training side
    assign train_dir  = resolve_valid_i && resolve_i.is_direct;
    assign train_cond = resolve_valid_i && resolve_i.is_cond;
    assign rs_bht_idx = bht_hash(resolve_i.pc);
    assign rs_pht_idx = bht[rs_bht_idx] ^ resolve_i.pc[BHR_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rr_ptr <= '0;
            for (int i = 0; i < BTB_NUM; i++) begin
                btb_vld[i] <= 1'b0;
            end
        end else if (train_dir) begin
            btb_vld[rr_ptr] <= 1'b1;
            rr_ptr          <= rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (train_dir) begin
            btb_tag[rr_ptr] <= resolve_i.pc[13:2];
            btb_tgt[rr_ptr] <= resolve_i.target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < BHT_NUM; i++) begin
                bht[i] <= '0;
            end
            for (int i = 0; i < PHT_NUM; i++) begin
                pht[i] <= S_NT0;
            end
        end else if (train_cond) begin
            bht[rs_bht_idx] <= {bht[rs_bht_idx][BHR_W-2:0], resolve_i.taken};
            pht[rs_pht_idx] <= ctr_next(pht[rs_pht_idx], resolve_i.taken);
        end
    end

    // taken outcomes only
    always_ff @(posedge clk) begin
        if (train_cond && resolve_i.taken) begin
            tc[rs_pht_idx] <= resolve_i.target;
        end
    end

    // back end reports one branch kind per resolve
    assert property (@(posedge clk) disable iff (!rstn)
        resolve_valid_i |-> !(resolve_i.is_direct && resolve_i.is_cond));

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import fe_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             flush_i,
    stage_if.receive        in,
    input  wire             out_ready_i,
    output logic            out_valid_o,
    output logic [XLEN-1:0] out_pc_o,
    output logic [31:0]     out_inst_o,
    output logic            out_exc_o,
    output br_class_e       out_class_o,
    output logic            out_pred_taken_o,
    output logic [XLEN-1:0] out_pred_target_o,
    output logic [XLEN-1:0] out_offs_target_o
);
    pd_item_t        item_q;
    logic            valid_q;
    logic [25:0]     offs26;
    logic [15:0]     offs16;
    logic [XLEN-1:0] sext26;
    logic [XLEN-1:0] sext16;

    assign in.allowin = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in.allowin) begin
            valid_q <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            item_q <= in.item;
        end
    end

    // b/bl split offset with the high part in inst[9:0]
    assign offs26 = {item_q.fetch.inst[9:0], item_q.fetch.inst[25:10]};
    assign offs16 = item_q.fetch.inst[25:10];
    assign sext26 = {{(XLEN-28){offs26[25]}}, offs26, 2'b00};
    assign sext16 = {{(XLEN-18){offs16[15]}}, offs16, 2'b00};

    // jirl target depends on a register so it stays 0
    always_comb begin
        case (item_q.br_class)
            BR_B, BR_BL: out_offs_target_o = item_q.fetch.pc + sext26;
            BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU:
                out_offs_target_o = item_q.fetch.pc + sext16;
            default: out_offs_target_o = '0;
        endcase
    end

    assign out_valid_o       = valid_q;
    assign out_pc_o          = item_q.fetch.pc;
    assign out_inst_o        = item_q.fetch.inst;
    assign out_exc_o         = item_q.fetch.exc;
    assign out_class_o       = item_q.br_class;
    assign out_pred_taken_o  = item_q.pred_taken;
    assign out_pred_target_o = item_q.pred_target;

endmodule

`default_nettype wire

/* fe_pkg.sv */
`default_nettype none

package fe_pkg;

    parameter int XLEN = 32;
    parameter logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    // major opcode field inst[31:26], branch group only
    typedef enum logic [5:0] {
        OP_JIRL = 6'h13,
        OP_B    = 6'h14,
        OP_BL   = 6'h15,
        OP_BEQ  = 6'h16,
        OP_BNE  = 6'h17,
        OP_BLT  = 6'h18,
        OP_BGE  = 6'h19,
        OP_BLTU = 6'h1a,
        OP_BGEU = 6'h1b
    } opcode_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_B, BR_BL, BR_JIRL,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_class_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic            exc;
    } fetch_item_t;

    // fetch item plus branch class and prediction
    typedef struct packed {
        fetch_item_t     fetch;
        br_class_e       br_class;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } pd_item_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
    import fe_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             flush_i,
    input  wire [XLEN-1:0]  flush_pc_i,
    input  wire             pred_redirect_i,
    input  wire [XLEN-1:0]  pred_pc_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  wire [31:0]      imem_rdata_i,
    input  wire             imem_err_i,
    stage_if.send           out
);
    logic [XLEN-1:0] pc_q;
    logic            valid_q;
    logic [XLEN-1:0] pc_next;
    logic            accept;
    fetch_item_t     item;

    assign accept = out.valid && out.allowin;

    // flush beats prediction, prediction beats pc+4
    always_comb begin
        if (flush_i) begin
            pc_next = flush_pc_i;
        end else if (pred_redirect_i) begin
            pc_next = pred_pc_i;
        end else begin
            pc_next = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            // a flush moves the pc even when pre-decode is stalled
            if (flush_i || accept) begin
                pc_q <= pc_next;
            end
        end
    end

    assign imem_addr_o = pc_q;

    // memory error travels with the item
    always_comb begin
        item.pc   = pc_q;
        item.inst = imem_rdata_i;
        item.exc  = imem_err_i;
    end

    assign out.valid = valid_q;
    assign out.item  = item;

    // redirect and flush targets come from other blocks and must stay word aligned
    assert property (@(posedge clk) disable iff (!rstn)
        valid_q |-> imem_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* frontend_top.sv */
`timescale 1ns/10ps
`default_nettype none

module frontend_top
    import fe_pkg::*;
    import bp_pkg::*;
#(
    parameter int BTB_NUM   = BTB_NUM_DEF,
    parameter int BHT_IDX_W = BHT_IDX_W_DEF,
    parameter int BHR_W     = BHR_W_DEF
) (
    input  wire             clk,
    input  wire             rstn,
    output logic [XLEN-1:0] imem_addr_o,
    input  wire [31:0]      imem_rdata_i,
    input  wire             imem_err_i,
    input  wire             out_ready_i,
    input  wire             resolve_valid_i,
    input  wire [XLEN-1:0]  resolve_pc_i,
    input  wire [XLEN-1:0]  resolve_target_i,
    input  wire             resolve_taken_i,
    input  wire             resolve_is_direct_i,
    input  wire             resolve_is_cond_i,
    input  wire             flush_i,
    input  wire [XLEN-1:0]  flush_pc_i,
    output logic            out_valid_o,
    output logic [XLEN-1:0] out_pc_o,
    output logic [31:0]     out_inst_o,
    output logic            out_exc_o,
    output br_class_e       out_class_o,
    output logic            out_pred_taken_o,
    output logic [XLEN-1:0] out_pred_target_o,
    output logic [XLEN-1:0] out_offs_target_o
);
    resolve_t        resolve;
    logic            pred_redirect;
    logic [XLEN-1:0] pred_pc;

    stage_if #(.item_t(fetch_item_t)) f2p_if ();
    stage_if #(.item_t(pd_item_t))    p2d_if ();

    assign resolve = '{pc: resolve_pc_i, target: resolve_target_i, taken: resolve_taken_i,
                       is_direct: resolve_is_direct_i, is_cond: resolve_is_cond_i};

    fetch_stage u_fetch (
        .clk             (clk),
        .rstn            (rstn),
        .flush_i         (flush_i),
        .flush_pc_i      (flush_pc_i),
        .pred_redirect_i (pred_redirect),
        .pred_pc_i       (pred_pc),
        .imem_addr_o     (imem_addr_o),
        .imem_rdata_i    (imem_rdata_i),
        .imem_err_i      (imem_err_i),
        .out             (f2p_if)
    );

    predecode_stage #(
        .BTB_NUM   (BTB_NUM),
        .BHT_IDX_W (BHT_IDX_W),
        .BHR_W     (BHR_W)
    ) u_predecode (
        .clk             (clk),
        .rstn            (rstn),
        .flush_i         (flush_i),
        .in              (f2p_if),
        .out             (p2d_if),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve),
        .pred_redirect_o (pred_redirect),
        .pred_pc_o       (pred_pc)
    );

    decode_stage u_decode (
        .clk               (clk),
        .rstn              (rstn),
        .flush_i           (flush_i),
        .in                (p2d_if),
        .out_ready_i       (out_ready_i),
        .out_valid_o       (out_valid_o),
        .out_pc_o          (out_pc_o),
        .out_inst_o        (out_inst_o),
        .out_exc_o         (out_exc_o),
        .out_class_o       (out_class_o),
        .out_pred_taken_o  (out_pred_taken_o),
        .out_pred_target_o (out_pred_target_o),
        .out_offs_target_o (out_offs_target_o)
    );

endmodule

`default_nettype wire

/* predecode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module predecode_stage
    import fe_pkg::*;
    import bp_pkg::*;
#(
    parameter int BTB_NUM   = BTB_NUM_DEF,
    parameter int BHT_IDX_W = BHT_IDX_W_DEF,
    parameter int BHR_W     = BHR_W_DEF
) (
    input  wire             clk,
    input  wire             rstn,
    input  wire             flush_i,
    stage_if.receive        in,
    stage_if.send           out,
    input  wire             resolve_valid_i,
    input  wire resolve_t   resolve_i,
    output logic            pred_redirect_o,
    output logic [XLEN-1:0] pred_pc_o
);
    fetch_item_t     item_q;
    logic            valid_q;
    logic            ex_flag_q;
    logic            load;
    opcode_e         opcode;
    br_class_e       br_class;
    logic            is_direct;
    logic            is_cond;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            cond_taken;
    logic [XLEN-1:0] tc_target;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    assign in.allowin = !valid_q || out.allowin;
    // wrong-path item behind a redirect never enters
    assign load = in.valid && in.allowin && !pred_redirect_o;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (in.allowin) begin
            valid_q <= load && !ex_flag_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.allowin) begin
            item_q <= in.item;
        end
    end

    // set once an exc item is taken in and blocks everything after it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_flag_q <= 1'b0;
        end else if (flush_i) begin
            ex_flag_q <= 1'b0;
        end else if (load && in.item.exc) begin
            ex_flag_q <= 1'b1;
        end
    end

    assign opcode = opcode_e'(item_q.inst[31:26]);

    always_comb begin
        case (opcode)
            OP_JIRL: br_class = BR_JIRL;
            OP_B:    br_class = BR_B;
            OP_BL:   br_class = BR_BL;
            OP_BEQ:  br_class = BR_BEQ;
            OP_BNE:  br_class = BR_BNE;
            OP_BLT:  br_class = BR_BLT;
            OP_BGE:  br_class = BR_BGE;
            OP_BLTU: br_class = BR_BLTU;
            OP_BGEU: br_class = BR_BGEU;
            default: br_class = BR_NONE;
        endcase
    end

    assign is_direct = br_class inside {BR_B, BR_BL, BR_JIRL};
    assign is_cond   = br_class inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    bp_tables #(
        .BTB_NUM   (BTB_NUM),
        .BHT_IDX_W (BHT_IDX_W),
        .BHR_W     (BHR_W)
    ) u_bp_tables (
        .clk             (clk),
        .rstn            (rstn),
        .lookup_pc_i     (item_q.pc),
        .hit_o           (btb_hit),
        .btb_target_o    (btb_target),
        .cond_taken_o    (cond_taken),
        .tc_target_o     (tc_target),
        .resolve_valid_i (resolve_valid_i),
        .resolve_i       (resolve_i)
    );

    // faulting fetches carry no usable opcode so nothing is predicted
    always_comb begin
        pred_taken  = 1'b0;
        pred_target = '0;
        if (!item_q.exc) begin
            if (is_direct && btb_hit) begin
                pred_taken  = 1'b1;
                pred_target = btb_target;
            end else if (is_cond && cond_taken) begin
                pred_taken  = 1'b1;
                pred_target = tc_target;
            end
        end
    end

    assign pred_redirect_o = valid_q && pred_taken;
    assign pred_pc_o       = pred_target;

    assign out.valid = valid_q;
    assign out.item  = '{fetch: item_q, br_class: br_class,
                         pred_taken: pred_taken, pred_target: pred_target};

    // predicted targets come from trained tables and must be word aligned
    assert property (@(posedge clk) disable iff (!rstn)
        pred_redirect_o |-> pred_pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
    -f sources.f -o sim_frontend

out=$(./obj_dir/sim_frontend)
echo "$out"

if echo "$out" | grep -q "TEST OK"; then
    exit 0
fi
exit 1

/* sources.f */
fe_pkg.sv
bp_pkg.sv
stage_if.sv
fetch_stage.sv
bp_tables.sv
predecode_stage.sv
decode_stage.sv
frontend_top.sv
tb_frontend.sv

/* stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

// valid/allowin link between two pipeline stages
// an item moves on an edge where valid and allowin are both high
interface stage_if #(
    parameter type item_t = logic
);
    logic  valid;
    logic  allowin;
    item_t item;

    modport send (
        output valid,
        output item,
        input  allowin
    );

    modport receive (
        input  valid,
        input  item,
        output allowin
    );
endinterface

`default_nettype wire

/* tb_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_frontend
    import fe_pkg::*;
    import bp_pkg::*;
();
    localparam int BTB_N    = BTB_NUM_DEF;
    localparam int BHT_W    = BHT_IDX_W_DEF;
    localparam int HIST_W   = BHR_W_DEF;
    localparam logic [31:0] BASE     = 32'h1c00_0000;
    localparam logic [31:0] ERR_ADDR = 32'h1c00_0408;
    localparam int TIMEOUT  = 80;
    localparam int N_ROWS   = 8;

    // one test step with optional training and flush before the expected stream
    typedef struct packed {
        logic        flush;
        logic [31:0] start_pc;
        logic [3:0]  res_n;
        logic [31:0] res_pc;
        logic [31:0] res_tgt;
        logic        res_taken;
        logic        res_dir;
        logic        res_cond;
        logic        stall;
        logic [7:0]  n_items;
        logic        exc_end;
        logic [31:0] last_pc;
    } row_t;

    logic        clk;
    logic        rstn;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        imem_err_i;
    logic        out_ready_i;
    logic        resolve_valid_i;
    logic [31:0] resolve_pc_i;
    logic [31:0] resolve_target_i;
    logic        resolve_taken_i;
    logic        resolve_is_direct_i;
    logic        resolve_is_cond_i;
    logic        flush_i;
    logic [31:0] flush_pc_i;
    logic        out_valid_o;
    logic [31:0] out_pc_o;
    logic [31:0] out_inst_o;
    logic        out_exc_o;
    br_class_e   out_class_o;
    logic        out_pred_taken_o;
    logic [31:0] out_pred_target_o;
    logic [31:0] out_offs_target_o;

    logic [31:0]       imem [1024];
    row_t              rows [N_ROWS];
    // reference predictor state
    logic              ref_vld [BTB_N];
    logic [11:0]       ref_tag [BTB_N];
    logic [31:0]       ref_tgt [BTB_N];
    int                ref_ptr;
    logic [HIST_W-1:0] ref_bht [2**BHT_W];
    int                ref_ctr [2**HIST_W];
    logic [31:0]       ref_tc  [2**HIST_W];
    int                errors;
    int                timeouts;
    integer            seed;
    logic              hold_v;
    logic [31:0]       hold_pc;
    logic [31:0]       hold_inst;
    logic [31:0]       hold_tgt;

    frontend_top #(
        .BTB_NUM   (BTB_N),
        .BHT_IDX_W (BHT_W),
        .BHR_W     (HIST_W)
    ) uut (
        .clk                 (clk),
        .rstn                (rstn),
        .imem_addr_o         (imem_addr_o),
        .imem_rdata_i        (imem_rdata_i),
        .imem_err_i          (imem_err_i),
        .out_ready_i         (out_ready_i),
        .resolve_valid_i     (resolve_valid_i),
        .resolve_pc_i        (resolve_pc_i),
        .resolve_target_i    (resolve_target_i),
        .resolve_taken_i     (resolve_taken_i),
        .resolve_is_direct_i (resolve_is_direct_i),
        .resolve_is_cond_i   (resolve_is_cond_i),
        .flush_i             (flush_i),
        .flush_pc_i          (flush_pc_i),
        .out_valid_o         (out_valid_o),
        .out_pc_o            (out_pc_o),
        .out_inst_o          (out_inst_o),
        .out_exc_o           (out_exc_o),
        .out_class_o         (out_class_o),
        .out_pred_taken_o    (out_pred_taken_o),
        .out_pred_target_o   (out_pred_target_o),
        .out_offs_target_o   (out_offs_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // non-branch opcode with every address bit folded into the word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h0a, addr[25:0] ^ {addr[31:26], 20'h0}};
    endfunction

    function automatic logic [31:0] enc26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] enc16(input logic [5:0] op, input logic [15:0] offs);
        return {op, offs, 10'h085};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (addr[31:12] == BASE[31:12]) begin
            return imem[addr[11:2]];
        end
        return fill_word(addr);
    endfunction

    always_comb begin
        imem_rdata_i = mem_word(imem_addr_o);
        imem_err_i   = (imem_addr_o === ERR_ADDR);
    end

    function automatic br_class_e classify(input logic [5:0] op);
        case (op)
            6'h13:   return BR_JIRL;
            6'h14:   return BR_B;
            6'h15:   return BR_BL;
            6'h16:   return BR_BEQ;
            6'h17:   return BR_BNE;
            6'h18:   return BR_BLT;
            6'h19:   return BR_BGE;
            6'h1a:   return BR_BLTU;
            6'h1b:   return BR_BGEU;
            default: return BR_NONE;
        endcase
    endfunction

    function automatic logic is_cond_class(input br_class_e c);
        return c inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    endfunction

    function automatic logic [31:0] offs_target(input logic [31:0] pc, input logic [31:0] inst);
        br_class_e c;
        c = classify(inst[31:26]);
        if (c == BR_B || c == BR_BL) begin
            return pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else if (is_cond_class(c)) begin
            return pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        end
        return 32'd0;
    endfunction

    // history table index from two folded xors added together
    function automatic int bht_index(input logic [31:0] pc);
        logic [31:0] sum;
        sum = (pc ^ (pc >> 16)) + (pc ^ (pc >> 8));
        return int'(sum & ((32'd1 << BHT_W) - 32'd1));
    endfunction

    task automatic ref_resolve(input row_t r);
        int h;
        int idx;
        if (r.res_dir) begin
            ref_vld[ref_ptr] = 1'b1;
            ref_tag[ref_ptr] = r.res_pc[13:2];
            ref_tgt[ref_ptr] = r.res_tgt;
            ref_ptr = (ref_ptr + 1) % BTB_N;
        end
        if (r.res_cond) begin
            h   = bht_index(r.res_pc);
            idx = int'(ref_bht[h] ^ r.res_pc[HIST_W-1:0]);
            if (r.res_taken) begin
                ref_ctr[idx] = (ref_ctr[idx] < 3) ? ref_ctr[idx] + 1 : 3;
                ref_tc[idx]  = r.res_tgt;
            end else begin
                ref_ctr[idx] = (ref_ctr[idx] > 0) ? ref_ctr[idx] - 1 : 0;
            end
            ref_bht[h] = {ref_bht[h][HIST_W-2:0], r.res_taken};
        end
    endtask

    task automatic predict(input logic [31:0] pc, input logic exc,
                           output logic taken, output logic [31:0] tgt);
        br_class_e   c;
        int          idx;
        logic [31:0] inst;
        inst  = mem_word(pc);
        c     = classify(inst[31:26]);
        taken = 1'b0;
        tgt   = 32'd0;
        if (!exc && c inside {BR_B, BR_BL, BR_JIRL}) begin
            // lowest matching entry wins
            for (int i = 0; i < BTB_N; i++) begin
                if (!taken && ref_vld[i] && ref_tag[i] == pc[13:2]) begin
                    taken = 1'b1;
                    tgt   = ref_tgt[i];
                end
            end
        end else if (!exc && is_cond_class(c)) begin
            idx = int'(ref_bht[bht_index(pc)] ^ pc[HIST_W-1:0]);
            if (ref_ctr[idx] >= 2) begin
                taken = 1'b1;
                tgt   = ref_tc[idx];
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("[FAIL] %s exp %h got %h (out_pc_o %h)", name, exp, got, out_pc_o);
    endtask

    task automatic check_item(input logic [31:0] pc, output logic [31:0] nxt);
        logic [31:0] inst;
        logic        exc;
        logic        taken;
        logic [31:0] tgt;
        inst = mem_word(pc);
        exc  = (pc == ERR_ADDR);
        predict(pc, exc, taken, tgt);
        if (out_pc_o !== pc)
            report_mismatch("out_pc_o", pc, out_pc_o);
        if (out_inst_o !== inst)
            report_mismatch("out_inst_o", inst, out_inst_o);
        if (out_exc_o !== exc)
            report_mismatch("out_exc_o", 32'(exc), 32'(out_exc_o));
        if (out_class_o !== classify(inst[31:26]))
            report_mismatch("out_class_o", 32'(classify(inst[31:26])), 32'(out_class_o));
        if (out_pred_taken_o !== taken)
            report_mismatch("out_pred_taken_o", 32'(taken), 32'(out_pred_taken_o));
        if (out_pred_target_o !== tgt)
            report_mismatch("out_pred_target_o", tgt, out_pred_target_o);
        if (out_offs_target_o !== offs_target(pc, inst))
            report_mismatch("out_offs_target_o", offs_target(pc, inst), out_offs_target_o);
        nxt = taken ? tgt : pc + 32'd4;
    endtask

    // a stalled item must not change
    task automatic check_hold();
        if (hold_v) begin
            if (out_valid_o !== 1'b1)
                report_mismatch("out_valid_o", 32'd1, 32'(out_valid_o));
            if (out_pc_o !== hold_pc)
                report_mismatch("out_pc_o", hold_pc, out_pc_o);
            if (out_inst_o !== hold_inst)
                report_mismatch("out_inst_o", hold_inst, out_inst_o);
            if (out_pred_target_o !== hold_tgt)
                report_mismatch("out_pred_target_o", hold_tgt, out_pred_target_o);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_row(input int num, input row_t r);
        logic [31:0] exp_pc;
        logic [31:0] nxt;
        logic [31:0] rnd;
        logic        rdy;
        int          got;
        int          idle;
        out_ready_i = 1'b1;
        hold_v      = 1'b0;
        // training lands together with the flush so the new stream sees it
        for (int i = 0; i < int'(r.res_n); i++) begin
            resolve_valid_i     = 1'b1;
            resolve_pc_i        = r.res_pc;
            resolve_target_i    = r.res_tgt;
            resolve_taken_i     = r.res_taken;
            resolve_is_direct_i = r.res_dir;
            resolve_is_cond_i   = r.res_cond;
            ref_resolve(r);
            if (r.flush && i == int'(r.res_n) - 1) begin
                flush_i    = 1'b1;
                flush_pc_i = r.start_pc;
            end
            next_cycle();
        end
        if (r.flush && r.res_n == 4'd0) begin
            flush_i    = 1'b1;
            flush_pc_i = r.start_pc;
            next_cycle();
        end
        resolve_valid_i = 1'b0;
        flush_i         = 1'b0;
        exp_pc = r.start_pc;
        got    = 0;
        idle   = 0;
        while (got < int'(r.n_items) && timeouts == 0) begin
            rnd = $random(seed);
            rdy = r.stall ? rnd[0] : 1'b1;
            out_ready_i = rdy;
            check_hold();
            if (out_valid_o && rdy) begin
                check_item(exp_pc, nxt);
                got++;
                idle = 0;
                if (got == int'(r.n_items) && out_pc_o !== r.last_pc)
                    report_mismatch("out_pc_o", r.last_pc, out_pc_o);
                exp_pc = nxt;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    timeouts++;
                    $display("row %0d: no item on out_valid_o within %0d cycles", num, TIMEOUT);
                end
            end
            hold_v    = out_valid_o && !rdy;
            hold_pc   = out_pc_o;
            hold_inst = out_inst_o;
            hold_tgt  = out_pred_target_o;
            next_cycle();
        end
        // nothing may follow a faulting item until the next flush
        if (r.exc_end && timeouts == 0) begin
            out_ready_i = 1'b1;
            hold_v      = 1'b0;
            repeat (12) begin
                next_cycle();
                if (out_valid_o !== 1'b0)
                    report_mismatch("out_valid_o", 32'd0, 32'(out_valid_o));
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = fill_word(BASE + 32'(i * 4));
        end
        imem[32'h004 >> 2] = enc26(OP_B, 26'h10);
        imem[32'h008 >> 2] = enc16(OP_BEQ, 16'h0008);
        imem[32'h00c >> 2] = enc16(OP_JIRL, 16'h0004);
        imem[32'h010 >> 2] = enc26(OP_BL, 26'h3fffffc);
        imem[32'h014 >> 2] = enc16(OP_BGEU, 16'hfffe);
        imem[32'h104 >> 2] = enc26(OP_B, 26'h1f);
        imem[32'h200 >> 2] = enc16(OP_BEQ, 16'h0010);
        imem[32'h300 >> 2] = enc16(OP_BNE, 16'h0020);
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        seed     = 32'h652d;
        ref_ptr  = 0;
        for (int i = 0; i < BTB_N; i++) begin
            ref_vld[i] = 1'b0;
        end
        for (int i = 0; i < 2**BHT_W; i++) begin
            ref_bht[i] = '0;
        end
        for (int i = 0; i < 2**HIST_W; i++) begin
            ref_ctr[i] = 0;
            ref_tc[i]  = 32'd0;
        end
        rstn                = 1'b0;
        out_ready_i         = 1'b1;
        resolve_valid_i     = 1'b0;
        resolve_pc_i        = 32'd0;
        resolve_target_i    = 32'd0;
        resolve_taken_i     = 1'b0;
        resolve_is_direct_i = 1'b0;
        resolve_is_cond_i   = 1'b0;
        flush_i             = 1'b0;
        flush_pc_i          = 32'd0;
        hold_v              = 1'b0;
        load_program();
        // flush, start, res_n, res_pc, res_tgt, taken, dir, cond, stall, n, exc_end, last
        rows[0] = '{1'b0, BASE, 4'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0,
                    1'b0, 8'd8, 1'b0, BASE + 32'h01c};
        rows[1] = '{1'b1, BASE + 32'h100, 4'd1, BASE + 32'h104, BASE + 32'h180, 1'b1, 1'b1, 1'b0,
                    1'b0, 8'd4, 1'b0, BASE + 32'h184};
        rows[2] = '{1'b1, BASE + 32'h1f8, 4'd7, BASE + 32'h200, BASE + 32'h240, 1'b1, 1'b0, 1'b1,
                    1'b0, 8'd5, 1'b0, BASE + 32'h244};
        rows[3] = '{1'b1, BASE + 32'h2f8, 4'd2, BASE + 32'h300, BASE + 32'h380, 1'b1, 1'b0, 1'b1,
                    1'b1, 8'd8, 1'b0, BASE + 32'h314};
        rows[4] = '{1'b1, BASE + 32'h104, 4'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0,
                    1'b1, 8'd6, 1'b0, BASE + 32'h190};
        rows[5] = '{1'b1, BASE + 32'h200, 4'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0,
                    1'b0, 8'd3, 1'b0, BASE + 32'h244};
        rows[6] = '{1'b1, BASE + 32'h400, 4'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0,
                    1'b0, 8'd3, 1'b1, BASE + 32'h408};
        rows[7] = '{1'b1, BASE + 32'h500, 4'd0, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0,
                    1'b1, 8'd4, 1'b0, BASE + 32'h50c};
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;
        for (int i = 0; i < N_ROWS && timeouts == 0; i++) begin
            run_row(i, rows[i]);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
